// File: design/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    // Datapath widths
    localparam int DATA_W     = 8;
    localparam int REG_ADDR_W = 3;
    localparam int NUM_REGS   = 8;
    localparam int IMM_W      = 4;
    localparam int INSTR_W    = 16;
    localparam int MEM_ADDR_W = 4;

    // Instruction field positions
    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;
    localparam int RD_MSB     = 11;
    localparam int RD_LSB     = 9;
    localparam int RS1_MSB    = 8;
    localparam int RS1_LSB    = 6;
    localparam int RS2_MSB    = 5;
    localparam int RS2_LSB    = 3;
    localparam int IMM_MSB    = 3;
    localparam int IMM_LSB    = 0;

    // Immediate forms reuse bits 3 to 0, so rs2 is ignored for them
    typedef enum logic [3:0] {
        NOP   = 4'd0,
        ADD   = 4'd1,
        SUB   = 4'd2,
        AND   = 4'd3,
        OR    = 4'd4,
        XOR   = 4'd5,
        SHL   = 4'd6,
        SHR   = 4'd7,
        ADDI  = 4'd8,
        LOAD  = 4'd9,
        STORE = 4'd10,
        BEQ   = 4'd11,
        JMP   = 4'd12,
        DONE  = 4'd13
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SHL = 3'd5,
        ALU_SHR = 3'd6
    } alu_op_e;

endpackage

`default_nettype wire

// File: design/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                          clock,
    input  wire logic                          rst_n,
    input  wire logic [pipe_pkg::INSTR_W-1:0]  instr,
    input  wire logic                          instr_valid,
    input  wire logic                          halted,
    input  wire logic                          rf_we,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] rf_waddr,
    input  wire logic [pipe_pkg::DATA_W-1:0]   rf_wdata,
    output logic [pipe_pkg::DATA_W-1:0]        id_val1,
    output logic [pipe_pkg::DATA_W-1:0]        id_val2,
    output logic [pipe_pkg::DATA_W-1:0]        id_aux_val,
    output logic [pipe_pkg::IMM_W-1:0]         id_imm,
    output logic [pipe_pkg::REG_ADDR_W-1:0]    id_read_addr1,
    output logic [pipe_pkg::REG_ADDR_W-1:0]    id_read_addr2,
    output logic [pipe_pkg::REG_ADDR_W-1:0]    id_write_addr,
    output pipe_pkg::alu_op_e                  id_alu_op,
    output logic                               id_alu_src,
    output logic                               id_reg_write,
    output logic                               id_mem_read,
    output logic                               id_mem_write,
    output logic                               id_branch_ctrl,
    output logic                               id_jmp_ctrl,
    output logic                               id_done_ctrl
);
    import pipe_pkg::*;

    opcode_e                opcode;
    logic                   valid;
    logic [DATA_W-1:0]      regs [NUM_REGS];

    assign opcode        = opcode_e'(instr[OPCODE_MSB:OPCODE_LSB]);
    assign valid         = instr_valid && !halted;
    assign id_write_addr = instr[RD_MSB:RD_LSB];
    assign id_read_addr1 = instr[RS1_MSB:RS1_LSB];
    assign id_read_addr2 = instr[RS2_MSB:RS2_LSB];
    assign id_imm        = instr[IMM_MSB:IMM_LSB];

    // Control decode, anything not accepted turns into a bubble
    always_comb begin
        id_alu_op      = ALU_ADD;
        id_alu_src     = 1'b0;
        id_reg_write   = 1'b0;
        id_mem_read    = 1'b0;
        id_mem_write   = 1'b0;
        id_branch_ctrl = 1'b0;
        id_jmp_ctrl    = 1'b0;
        id_done_ctrl   = 1'b0;
        if (valid) begin
            case (opcode)
                ADD:   begin id_alu_op = ALU_ADD; id_reg_write = 1'b1; end
                SUB:   begin id_alu_op = ALU_SUB; id_reg_write = 1'b1; end
                AND:   begin id_alu_op = ALU_AND; id_reg_write = 1'b1; end
                OR:    begin id_alu_op = ALU_OR;  id_reg_write = 1'b1; end
                XOR:   begin id_alu_op = ALU_XOR; id_reg_write = 1'b1; end
                SHL:   begin id_alu_op = ALU_SHL; id_reg_write = 1'b1; end
                SHR:   begin id_alu_op = ALU_SHR; id_reg_write = 1'b1; end
                ADDI:  begin id_alu_src = 1'b1; id_reg_write = 1'b1; end
                LOAD:  begin
                    id_alu_src   = 1'b1;
                    id_mem_read  = 1'b1;
                    id_reg_write = 1'b1;
                end
                STORE: begin id_alu_src = 1'b1; id_mem_write = 1'b1; end
                BEQ:   id_branch_ctrl = 1'b1;
                JMP:   id_jmp_ctrl = 1'b1;
                DONE:  id_done_ctrl = 1'b1;
                default: ;
            endcase
        end
    end

    // Register file, written from the result stage
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    // Write-through so a value being written this cycle is seen by decode
    assign id_val1 = (rf_we && rf_waddr == id_read_addr1) ? rf_wdata : regs[id_read_addr1];
    assign id_val2 = (rf_we && rf_waddr == id_read_addr2) ? rf_wdata : regs[id_read_addr2];
    assign id_aux_val = (rf_we && rf_waddr == id_write_addr) ? rf_wdata
                                                             : regs[id_write_addr];

endmodule

`default_nettype wire

// File: design/pipe_id_mex.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_id_mex (
    input  wire logic                            clock,
    input  wire logic                            rst_n,
    input  wire logic                            flush,
    input  wire logic [pipe_pkg::DATA_W-1:0]     id_val1,
    input  wire logic [pipe_pkg::DATA_W-1:0]     id_val2,
    input  wire logic [pipe_pkg::DATA_W-1:0]     id_aux_val,
    input  wire logic [pipe_pkg::IMM_W-1:0]      id_imm,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_read_addr1,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_read_addr2,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] id_write_addr,
    input  pipe_pkg::alu_op_e                    id_alu_op,
    input  wire logic                            id_alu_src,
    input  wire logic                            id_reg_write,
    input  wire logic                            id_mem_read,
    input  wire logic                            id_mem_write,
    input  wire logic                            id_branch_ctrl,
    input  wire logic                            id_jmp_ctrl,
    input  wire logic                            id_done_ctrl,
    output logic [pipe_pkg::DATA_W-1:0]          ex_val1,
    output logic [pipe_pkg::DATA_W-1:0]          ex_val2,
    output logic [pipe_pkg::DATA_W-1:0]          ex_aux_val,
    output logic [pipe_pkg::IMM_W-1:0]           ex_imm,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      ex_read_addr1,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      ex_read_addr2,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      ex_write_addr,
    output pipe_pkg::alu_op_e                    ex_alu_op,
    output logic                                 ex_alu_src,
    output logic                                 ex_reg_write,
    output logic                                 ex_mem_read,
    output logic                                 ex_mem_write,
    output logic                                 ex_branch_ctrl,
    output logic                                 ex_jmp_ctrl,
    output logic                                 ex_done_ctrl
);
    import pipe_pkg::*;

    // Control flags, a flush turns the slot into a bubble
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_alu_src     <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_branch_ctrl <= 1'b0;
            ex_jmp_ctrl    <= 1'b0;
            ex_done_ctrl   <= 1'b0;
        end else if (flush) begin
            ex_alu_src     <= 1'b0;
            ex_reg_write   <= 1'b0;
            ex_mem_read    <= 1'b0;
            ex_mem_write   <= 1'b0;
            ex_branch_ctrl <= 1'b0;
            ex_jmp_ctrl    <= 1'b0;
            ex_done_ctrl   <= 1'b0;
        end else begin
            ex_alu_src     <= id_alu_src;
            ex_reg_write   <= id_reg_write;
            ex_mem_read    <= id_mem_read;
            ex_mem_write   <= id_mem_write;
            ex_branch_ctrl <= id_branch_ctrl;
            ex_jmp_ctrl    <= id_jmp_ctrl;
            ex_done_ctrl   <= id_done_ctrl;
        end
    end

    // Operands and addresses follow decode every cycle
    always_ff @(posedge clock) begin
        ex_val1       <= id_val1;
        ex_val2       <= id_val2;
        ex_aux_val    <= id_aux_val;
        ex_imm        <= id_imm;
        ex_read_addr1 <= id_read_addr1;
        ex_read_addr2 <= id_read_addr2;
        ex_write_addr <= id_write_addr;
        ex_alu_op     <= id_alu_op;
    end

endmodule

`default_nettype wire

// File: design/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  wire logic                            clock,
    input  wire logic [pipe_pkg::DATA_W-1:0]     ex_val1,
    input  wire logic [pipe_pkg::DATA_W-1:0]     ex_val2,
    input  wire logic [pipe_pkg::DATA_W-1:0]     ex_aux_val,
    input  wire logic [pipe_pkg::IMM_W-1:0]      ex_imm,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] ex_read_addr1,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] ex_read_addr2,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] ex_write_addr,
    input  pipe_pkg::alu_op_e                    ex_alu_op,
    input  wire logic                            ex_alu_src,
    input  wire logic                            ex_reg_write,
    input  wire logic                            ex_mem_read,
    input  wire logic                            ex_mem_write,
    input  wire logic                            ex_branch_ctrl,
    input  wire logic                            ex_jmp_ctrl,
    input  wire logic                            ex_done_ctrl,
    input  wire logic                            rf_we,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] rf_waddr,
    input  wire logic [pipe_pkg::DATA_W-1:0]     rf_wdata,
    output logic [pipe_pkg::DATA_W-1:0]          result,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      res_write_addr,
    output logic                                 res_reg_write,
    output logic                                 res_done,
    output logic                                 redirect,
    output logic [pipe_pkg::DATA_W-1:0]          redirect_target,
    output logic                                 flush
);
    import pipe_pkg::*;

    logic [DATA_W-1:0]     op1;
    logic [DATA_W-1:0]     op2;
    logic [DATA_W-1:0]     aux;
    logic [DATA_W-1:0]     alu_b;
    logic [DATA_W-1:0]     alu_out;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0]     dmem [2**MEM_ADDR_W];
    logic                  taken;

    // Forward the value sitting in the result stage
    assign op1 = (rf_we && rf_waddr == ex_read_addr1) ? rf_wdata : ex_val1;
    assign op2 = (rf_we && rf_waddr == ex_read_addr2) ? rf_wdata : ex_val2;
    assign aux = (rf_we && rf_waddr == ex_write_addr) ? rf_wdata : ex_aux_val;

    assign alu_b = ex_alu_src ? {{(DATA_W - IMM_W){1'b0}}, ex_imm} : op2;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD: alu_out = op1 + alu_b;
            ALU_SUB: alu_out = op1 - alu_b;
            ALU_AND: alu_out = op1 & alu_b;
            ALU_OR:  alu_out = op1 | alu_b;
            ALU_XOR: alu_out = op1 ^ alu_b;
            ALU_SHL: alu_out = op1 << alu_b[2:0];
            ALU_SHR: alu_out = op1 >> alu_b[2:0];
            default: alu_out = op1 + alu_b;
        endcase
    end

    // Address wraps at 16 bytes
    assign mem_addr = alu_out[MEM_ADDR_W-1:0];

    always_ff @(posedge clock) begin
        if (ex_mem_write) begin
            dmem[mem_addr] <= aux;
        end
    end

    assign result = ex_mem_read ? dmem[mem_addr] : alu_out;

    assign res_write_addr = ex_write_addr;
    assign res_reg_write  = ex_reg_write;
    assign res_done       = ex_done_ctrl;

    // Branch target is the value of rd
    assign taken           = (ex_branch_ctrl && op1 == op2) || ex_jmp_ctrl;
    assign redirect        = taken;
    assign redirect_target = aux;
    assign flush           = taken || ex_done_ctrl;

endmodule

`default_nettype wire

// File: design/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  wire logic                            clock,
    input  wire logic                            rst_n,
    input  wire logic [pipe_pkg::DATA_W-1:0]     result,
    input  wire logic [pipe_pkg::REG_ADDR_W-1:0] res_write_addr,
    input  wire logic                            res_reg_write,
    input  wire logic                            res_done,
    output logic                                 rf_we,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      rf_waddr,
    output logic [pipe_pkg::DATA_W-1:0]          rf_wdata,
    output logic                                 halted
);
    import pipe_pkg::*;

    // Write enable and halt state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            rf_we  <= 1'b0;
            halted <= 1'b0;
        end else begin
            rf_we <= res_reg_write;
            // Sticky until the next reset
            if (res_done) begin
                halted <= 1'b1;
            end
        end
    end

    // Write-back payload, also the forwarding source
    always_ff @(posedge clock) begin
        rf_waddr <= res_write_addr;
        rf_wdata <= result[DATA_W-1:0];
    end

endmodule

`default_nettype wire

// File: design/pipe_core.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core (
    input  wire logic                            clock,
    input  wire logic                            rst_n,
    input  wire logic [pipe_pkg::INSTR_W-1:0]    instr,
    input  wire logic                            instr_valid,
    output logic                                 wb_valid,
    output logic [pipe_pkg::REG_ADDR_W-1:0]      wb_addr,
    output logic [pipe_pkg::DATA_W-1:0]          wb_data,
    output logic                                 redirect,
    output logic [pipe_pkg::DATA_W-1:0]          redirect_target,
    output logic                                 halted
);
    import pipe_pkg::*;

    logic [DATA_W-1:0]     id_val1, id_val2, id_aux_val;
    logic [IMM_W-1:0]      id_imm;
    logic [REG_ADDR_W-1:0] id_read_addr1, id_read_addr2, id_write_addr;
    alu_op_e               id_alu_op;
    logic                  id_alu_src, id_reg_write, id_mem_read, id_mem_write;
    logic                  id_branch_ctrl, id_jmp_ctrl, id_done_ctrl;

    logic [DATA_W-1:0]     ex_val1, ex_val2, ex_aux_val;
    logic [IMM_W-1:0]      ex_imm;
    logic [REG_ADDR_W-1:0] ex_read_addr1, ex_read_addr2, ex_write_addr;
    alu_op_e               ex_alu_op;
    logic                  ex_alu_src, ex_reg_write, ex_mem_read, ex_mem_write;
    logic                  ex_branch_ctrl, ex_jmp_ctrl, ex_done_ctrl;

    logic                  flush;
    logic [DATA_W-1:0]     result;
    logic [REG_ADDR_W-1:0] res_write_addr;
    logic                  res_reg_write, res_done;
    logic                  rf_we;
    logic [REG_ADDR_W-1:0] rf_waddr;
    logic [DATA_W-1:0]     rf_wdata;

    decode_stage u_decode (
        .clock, .rst_n, .instr, .instr_valid, .halted,
        .rf_we, .rf_waddr, .rf_wdata,
        .id_val1, .id_val2, .id_aux_val, .id_imm,
        .id_read_addr1, .id_read_addr2, .id_write_addr,
        .id_alu_op, .id_alu_src, .id_reg_write, .id_mem_read, .id_mem_write,
        .id_branch_ctrl, .id_jmp_ctrl, .id_done_ctrl
    );

    pipe_id_mex u_id_mex (
        .clock, .rst_n, .flush,
        .id_val1, .id_val2, .id_aux_val, .id_imm,
        .id_read_addr1, .id_read_addr2, .id_write_addr,
        .id_alu_op, .id_alu_src, .id_reg_write, .id_mem_read, .id_mem_write,
        .id_branch_ctrl, .id_jmp_ctrl, .id_done_ctrl,
        .ex_val1, .ex_val2, .ex_aux_val, .ex_imm,
        .ex_read_addr1, .ex_read_addr2, .ex_write_addr,
        .ex_alu_op, .ex_alu_src, .ex_reg_write, .ex_mem_read, .ex_mem_write,
        .ex_branch_ctrl, .ex_jmp_ctrl, .ex_done_ctrl
    );

    execute_stage u_execute (
        .clock,
        .ex_val1, .ex_val2, .ex_aux_val, .ex_imm,
        .ex_read_addr1, .ex_read_addr2, .ex_write_addr,
        .ex_alu_op, .ex_alu_src, .ex_reg_write, .ex_mem_read, .ex_mem_write,
        .ex_branch_ctrl, .ex_jmp_ctrl, .ex_done_ctrl,
        .rf_we, .rf_waddr, .rf_wdata,
        .result, .res_write_addr, .res_reg_write, .res_done,
        .redirect, .redirect_target, .flush
    );

    result_stage u_result (
        .clock, .rst_n,
        .result, .res_write_addr, .res_reg_write, .res_done,
        .rf_we, .rf_waddr, .rf_wdata, .halted
    );

    // Write-back port seen from outside
    assign wb_valid = rf_we;
    assign wb_addr  = rf_waddr;
    assign wb_data  = rf_wdata;

endmodule

`default_nettype wire

// File: dv/pipe_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core_checker (
    input wire logic clock,
    input wire logic rst_n,
    input wire logic redirect,
    input wire logic wb_valid,
    input wire logic halted
);

    // Pipeline comes out of reset holding a bubble
    assert property (@(posedge clock) $rose(rst_n) |-> !redirect)
        else $error("redirect high right after reset");

    // The flushed slot behind a redirect cannot redirect again
    assert property (@(posedge clock) disable iff (!rst_n) redirect |=> !redirect)
        else $error("redirect held for more than one cycle");

    assert property (@(posedge clock) disable iff (!rst_n) halted |=> halted)
        else $error("halted dropped without reset");

    assert property (@(posedge clock) disable iff (!rst_n) halted |=> !wb_valid)
        else $error("register write after halt");

endmodule

bind pipe_core pipe_core_checker u_checker (
    .clock, .rst_n, .redirect, .wb_valid, .halted
);

`default_nettype wire

// File: dv/pipe_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_core_tb;
    import pipe_pkg::*;

    localparam int TBL_MAX = 64;

    logic                  clock;
    logic                  rst_n;
    logic [INSTR_W-1:0]    instr;
    logic                  instr_valid;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [DATA_W-1:0]     wb_data;
    logic                  redirect;
    logic [DATA_W-1:0]     redirect_target;
    logic                  halted;

    // Stimulus table with expected responses
    logic [INSTR_W-1:0]    t_instr  [TBL_MAX];
    logic                  t_valid  [TBL_MAX];
    logic                  t_wb     [TBL_MAX];
    logic [REG_ADDR_W-1:0] t_waddr  [TBL_MAX];
    logic [DATA_W-1:0]     t_wdata  [TBL_MAX];
    logic                  t_redir  [TBL_MAX];
    logic [DATA_W-1:0]     t_target [TBL_MAX];
    logic                  t_halt   [TBL_MAX];
    string                 t_name   [TBL_MAX];
    int                    n_entries;

    // Reference model state
    logic [DATA_W-1:0]     m_regs [NUM_REGS];
    logic [DATA_W-1:0]     m_mem  [2**MEM_ADDR_W];
    logic                  m_squash;
    logic                  m_halt;
    integer                seed;

    pipe_core uut (
        .clock, .rst_n, .instr, .instr_valid,
        .wb_valid, .wb_addr, .wb_data, .redirect, .redirect_target, .halted
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    function automatic logic [INSTR_W-1:0] rtype_word(opcode_e op, int rd, int rs1, int rs2);
        return {op, rd[2:0], rs1[2:0], rs2[2:0], 3'b000};
    endfunction

    function automatic logic [INSTR_W-1:0] itype_word(opcode_e op, int rd, int rs1, int imm);
        return {op, rd[2:0], rs1[2:0], 2'b00, imm[3:0]};
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "stopping at the first error");
    endtask

    // Runs one instruction through the model and records what the DUT must show
    task automatic add_entry(input logic [INSTR_W-1:0] ins, input logic vld, input string name);
        opcode_e               op;
        logic [REG_ADDR_W-1:0] rd;
        logic [DATA_W-1:0]     a;
        logic [DATA_W-1:0]     b;
        logic [DATA_W-1:0]     res;
        logic [MEM_ADDR_W-1:0] addr;
        logic                  wr;
        op   = opcode_e'(ins[OPCODE_MSB:OPCODE_LSB]);
        rd   = ins[RD_MSB:RD_LSB];
        a    = m_regs[ins[RS1_MSB:RS1_LSB]];
        b    = m_regs[ins[RS2_MSB:RS2_LSB]];
        addr = a[MEM_ADDR_W-1:0] + ins[IMM_MSB:IMM_LSB];
        res  = '0;
        wr   = 1'b0;
        t_instr[n_entries]  = ins;
        t_valid[n_entries]  = vld;
        t_name[n_entries]   = name;
        t_redir[n_entries]  = 1'b0;
        t_target[n_entries] = '0;
        if (vld && !m_squash && !m_halt) begin
            wr = 1'b1;
            case (op)
                ADD:     res = a + b;
                SUB:     res = a - b;
                AND:     res = a & b;
                OR:      res = a | b;
                XOR:     res = a ^ b;
                SHL:     res = a << b[2:0];
                SHR:     res = a >> b[2:0];
                ADDI:    res = a + {4'b0000, ins[IMM_MSB:IMM_LSB]};
                LOAD:    res = m_mem[addr];
                default: wr = 1'b0;
            endcase
            if (op == STORE) begin
                m_mem[addr] = m_regs[rd];
            end
            // A taken redirect or a halt squashes the next slot
            m_squash = (op == BEQ && a == b) || op == JMP || op == DONE;
            if (op == BEQ && a == b || op == JMP) begin
                t_redir[n_entries]  = 1'b1;
                t_target[n_entries] = m_regs[rd];
            end
            if (op == DONE) begin
                m_halt = 1'b1;
            end
            if (wr) begin
                m_regs[rd] = res;
            end
        end else begin
            m_squash = 1'b0;
        end
        t_wb[n_entries]    = wr;
        t_waddr[n_entries] = rd;
        t_wdata[n_entries] = res;
        t_halt[n_entries]  = m_halt;
        n_entries++;
    endtask

    task automatic check_wb(input string name, input logic exp_valid,
                            input logic [REG_ADDR_W-1:0] exp_addr,
                            input logic [DATA_W-1:0] exp_data);
        if (wb_valid !== exp_valid) begin
            $display("CHECK FAILED: %s wb_valid expected %0b actual %0b",
                     name, exp_valid, wb_valid);
            abort_run();
        end else if (exp_valid && (wb_addr !== exp_addr || wb_data !== exp_data)) begin
            $display("CHECK FAILED: %s write expected r%0d=%h actual r%0d=%h",
                     name, exp_addr, exp_data, wb_addr, wb_data);
            abort_run();
        end
    endtask

    task automatic check_redirect(input string name, input logic exp_redir,
                                  input logic [DATA_W-1:0] exp_target);
        if (redirect !== exp_redir || (exp_redir && redirect_target !== exp_target)) begin
            $display("CHECK FAILED: %s redirect expected %0b/%h actual %0b/%h",
                     name, exp_redir, exp_target, redirect, redirect_target);
            abort_run();
        end
    endtask

    task automatic check_halted(input string name, input logic exp_halted);
        if (halted !== exp_halted) begin
            $display("CHECK FAILED: %s halted expected %0b actual %0b",
                     name, exp_halted, halted);
            abort_run();
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        instr       = '0;
        instr_valid = 1'b0;
        n_entries   = 0;
        m_squash    = 1'b0;
        m_halt      = 1'b0;
        seed        = 73721;
        for (int r = 0; r < NUM_REGS; r++) begin
            m_regs[r] = '0;
        end
        for (int k = 0; k < 2**MEM_ADDR_W; k++) begin
            m_mem[k] = '0;
        end

        // Random constants, then dependent ALU operations back to back
        for (int r = 1; r < 5; r++) begin
            add_entry(itype_word(ADDI, r, 0, $random(seed)), 1'b1, "addi_const");
        end
        add_entry(itype_word(ADDI, 1, 1, $random(seed)), 1'b1, "addi_accum");
        add_entry(rtype_word(ADD, 5, 1, 2), 1'b1, "alu_add");
        add_entry(rtype_word(SUB, 6, 5, 3), 1'b1, "alu_sub_fwd");
        add_entry(rtype_word(AND, 7, 6, 5), 1'b1, "alu_and");
        add_entry(rtype_word(OR, 1, 7, 6), 1'b1, "alu_or");
        add_entry(rtype_word(XOR, 2, 1, 7), 1'b1, "alu_xor");
        add_entry(rtype_word(SHL, 3, 2, 4), 1'b1, "alu_shl");
        add_entry(rtype_word(SHR, 4, 3, 1), 1'b1, "alu_shr");
        // Memory round trips
        add_entry(itype_word(STORE, 5, 1, 3), 1'b1, "store_a");
        add_entry(itype_word(LOAD, 6, 1, 3), 1'b1, "load_a");
        add_entry(itype_word(STORE, 2, 0, 9), 1'b1, "store_b");
        add_entry(itype_word(ADDI, 7, 0, 1), 1'b1, "gap_addi");
        add_entry(itype_word(LOAD, 3, 0, 9), 1'b1, "load_b");
        // Branches
        add_entry(itype_word(ADDI, 4, 0, 7), 1'b1, "beq_setup1");
        add_entry(itype_word(ADDI, 5, 0, 7), 1'b1, "beq_setup2");
        add_entry(itype_word(ADDI, 6, 0, 12), 1'b1, "beq_setup3");
        add_entry(rtype_word(BEQ, 6, 4, 5), 1'b1, "beq_taken");
        add_entry(itype_word(ADDI, 7, 0, 1), 1'b1, "beq_shadow");
        add_entry(rtype_word(BEQ, 6, 4, 6), 1'b1, "beq_not_taken");
        add_entry(itype_word(ADDI, 7, 0, 2), 1'b1, "after_beq");
        add_entry(rtype_word(JMP, 3, 0, 0), 1'b1, "jmp");
        add_entry(rtype_word(ADD, 1, 2, 3), 1'b1, "jmp_shadow");
        // Bubbles and NOP
        add_entry(itype_word(ADDI, 1, 0, 5), 1'b0, "bubble");
        add_entry(rtype_word(NOP, 2, 0, 0), 1'b1, "nop");
        add_entry(rtype_word(ADD, 2, 1, 0), 1'b1, "readback");
        // Halt, nothing after it may act
        add_entry(rtype_word(DONE, 0, 0, 0), 1'b1, "done");
        add_entry(itype_word(ADDI, 1, 0, 3), 1'b1, "halt_shadow");
        add_entry(rtype_word(JMP, 3, 0, 0), 1'b1, "jmp_halted");
        add_entry(rtype_word(ADD, 5, 1, 2), 1'b1, "add_halted");

        repeat (10) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        check_wb("reset", 1'b0, '0, '0);
        check_redirect("reset", 1'b0, '0);
        check_halted("reset", 1'b0);

        // Redirect shows one edge after capture, the write one edge later
        for (int i = 0; i < n_entries + 2; i++) begin
            @(posedge clock);
            if (i < n_entries) begin
                instr       <= t_instr[i];
                instr_valid <= t_valid[i];
            end else begin
                instr       <= '0;
                instr_valid <= 1'b0;
            end
            @(negedge clock);
            if (i >= 1 && i - 1 < n_entries) begin
                check_redirect(t_name[i-1], t_redir[i-1], t_target[i-1]);
            end
            if (i >= 2) begin
                check_wb(t_name[i-2], t_wb[i-2], t_waddr[i-2], t_wdata[i-2]);
                check_halted(t_name[i-2], t_halt[i-2]);
            end
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
design/pipe_pkg.sv
design/decode_stage.sv
design/pipe_id_mex.sv
design/execute_stage.sv
design/result_stage.sv
design/pipe_core.sv
dv/pipe_core_checker.sv
dv/pipe_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the pipe_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module pipe_core_tb -o pipe_core_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/pipe_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "All tests passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
